//--- include/neopixel_macros.svh
`ifndef NEOPIXEL_MACROS_SVH
`define NEOPIXEL_MACROS_SVH

// last valid pixel index of the buffer, so the buffer holds 64 pixels
`define BUFFER_END_DEFAULT 63

// index width needed to address BUFFER_END_DEFAULT+1 entries
`define BUFFER_BITS 6

// low time after a frame in 7 MHz cycles, about 57 us which latches the LEDs
`define RESET_SLOTS 400

// each bit is 8 slots long and the line is high while the slot is below these
`define SLOTS_HIGH_ZERO 3
`define SLOTS_HIGH_ONE 6

// word offsets inside the register window (paddr bit 15 set)
`define REG_CTRL_OFS 0
`define REG_MAX_OFS 1
`define REG_STATUS_OFS 2

// paddr bit that selects the register window instead of the buffer
`define REG_WINDOW_BIT 15

`endif

//--- verilog/neopixel_pkg.sv
`default_nettype none

`include "neopixel_macros.svh"

package neopixel_pkg;

  typedef logic [23:0] pixel_t;                  // one GRB pixel, G in the top byte
  typedef logic [`BUFFER_BITS-1:0] pix_idx_t;    // buffer entry index
  typedef logic [12:0] max_t;                    // software maximum as written over APB
  typedef logic [2:0] slot_t;                    // sub-bit slot, 8 per data bit
  typedef logic [4:0] bit_idx_t;                 // bit within a pixel, 0 to 23

  // control register, init sits in bit 0
  typedef struct packed {
    logic stride4;  // take every fourth buffer entry
    logic limit;    // use the software maximum instead of the buffer end
    logic run;      // stream frames
    logic init;     // hold everything in its start state
  } ctrl_reg_t;

  // strobes from the stream counters
  typedef struct packed {
    logic output_en;   // transmitting and allowed to run
    logic reset_en;    // in the gap and allowed to run
    logic pattern_of;  // last slot of a bit
    logic bit_of;      // last slot of the last bit of a pixel
    logic pixel_of;    // current pixel is the last one of the frame
  } stream_strb_t;

  typedef enum logic {
    st_reset    = 1'b0,  // line held low to latch the chain
    st_transmit = 1'b1   // pixel data going out
  } seq_state_e;

endpackage

`default_nettype wire

//--- verilog/neopixel_apb_regs.sv
`default_nettype none

`include "neopixel_macros.svh"

module neopixel_apb_regs
  import neopixel_pkg::*;
(
  input  wire logic        clk7mhz,
  input  wire logic        rst_n,
  input  wire logic        psel,
  input  wire logic        penable,
  input  wire logic        pwrite,
  input  wire logic [15:0] paddr,
  input  wire logic [31:0] pwdata,
  input  wire seq_state_e  state,
  input  wire pix_idx_t    pixel_index,
  output logic [31:0]      prdata,
  output logic             pready,
  output ctrl_reg_t        ctrl,
  output max_t             reg_max,
  output logic             buf_we,
  output pix_idx_t         buf_waddr,
  output pixel_t           buf_wdata
);

  logic        access;     // access phase of a transfer
  logic        reg_win;    // address falls in the register window
  logic [12:0] reg_ofs;    // word offset inside the register window
  logic        wr_access;

  assign access    = psel && penable;
  assign wr_access = access && pwrite;
  assign reg_win   = paddr[`REG_WINDOW_BIT];
  assign reg_ofs   = paddr[14:2];  // the two low bits are the byte lane

  // there are no wait states so every access completes at once
  assign pready = 1'b1;

  // buffer writes go straight through to the memory write port
  assign buf_we    = wr_access && !reg_win;
  assign buf_waddr = paddr[`BUFFER_BITS+1:2];  // word aligned pixel entry
  assign buf_wdata = pwdata[23:0];             // the top byte has no meaning for GRB

  always_ff @(posedge clk7mhz or negedge rst_n) begin
    if (!rst_n) begin
      ctrl    <= '0;  // run is off after reset so the line stays low
      reg_max <= '0;
    end else if (wr_access && reg_win) begin
      if (reg_ofs == 13'(`REG_CTRL_OFS)) begin
        ctrl <= ctrl_reg_t'(pwdata[3:0]);
      end
      if (reg_ofs == 13'(`REG_MAX_OFS)) begin
        reg_max <= pwdata[12:0];
      end
      // the status offset is read only and a write there is ignored
    end
  end

  // read data, unused bits and the write-only buffer read as zero
  always_comb begin
    prdata = '0;
    if (reg_win) begin
      case (reg_ofs)
        13'(`REG_CTRL_OFS): prdata[3:0]  = ctrl;
        13'(`REG_MAX_OFS):  prdata[12:0] = reg_max;
        13'(`REG_STATUS_OFS): begin
          prdata[0] = (state == st_transmit);       // 1 while pixels go out
          prdata[8 +: `BUFFER_BITS] = pixel_index;  // pixel currently on the line
        end
        default: prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/neopixel_pixel_buffer.sv
`default_nettype none

`include "neopixel_macros.svh"

module neopixel_pixel_buffer
  import neopixel_pkg::*;
#(
  parameter int DEPTH = `BUFFER_END_DEFAULT + 1  // index width must cover DEPTH entries
) (
  input  wire logic     clk7mhz,
  input  wire logic     we,
  input  wire pix_idx_t waddr,
  input  wire pixel_t   wdata,
  input  wire pix_idx_t raddr,
  output pixel_t        rdata
);

  // plain array so synthesis maps it to distributed or block RAM
  pixel_t mem [DEPTH];

  // APB side write port
  always_ff @(posedge clk7mhz) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // stream side read, one cycle of latency
  // the index moves on the last slot of a pixel so rdata is fresh from slot 1
  always_ff @(posedge clk7mhz) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

//--- verilog/neopixel_stream_ctrl.sv
`default_nettype none

`include "neopixel_macros.svh"

module neopixel_stream_ctrl
  import neopixel_pkg::*;
#(
  parameter int BUFFER_END = `BUFFER_END_DEFAULT  // last pixel sent when limit is off
) (
  input  wire logic       clk7mhz,
  input  wire logic       rst_n,
  input  wire ctrl_reg_t  ctrl,
  input  wire seq_state_e state,
  input  wire max_t       reg_max,
  output slot_t           slot,
  output bit_idx_t        bit_index,
  output pix_idx_t        pixel_index,
  output stream_strb_t    strb
);

  pix_idx_t index_max;    // last pixel of the frame
  pix_idx_t index_equiv;  // current index as compared against index_max
  pix_idx_t max_equiv;
  pix_idx_t index_step;   // 1 normally, 4 under stride4
  logic     active;       // running and not held in init

  assign active = ctrl.run && !ctrl.init;

  assign strb.output_en  = active && (state == st_transmit);
  assign strb.reset_en   = active && (state == st_reset);
  assign strb.pattern_of = strb.output_en && (slot == 3'd7);         // last slot of a bit
  assign strb.bit_of     = strb.pattern_of && (bit_index == 5'd23);  // last bit of a pixel

  // software maximum only counts when limit is set, else the whole buffer
  assign index_max = ctrl.limit ? reg_max[`BUFFER_BITS-1:0] : pix_idx_t'(BUFFER_END);

  // under stride4 both sides get the low two bits set
  // so the frame ends on the last multiple of 4 at or below the maximum
  assign index_equiv = ctrl.stride4 ? {pixel_index[`BUFFER_BITS-1:2], 2'b11} : pixel_index;
  assign max_equiv   = ctrl.stride4 ? {index_max[`BUFFER_BITS-1:2], 2'b11} : index_max;
  assign strb.pixel_of = (index_equiv == max_equiv);

  assign index_step = ctrl.stride4 ? pix_idx_t'(4) : pix_idx_t'(1);

  always_ff @(posedge clk7mhz or negedge rst_n) begin
    if (!rst_n) begin
      slot        <= '0;
      bit_index   <= '0;
      pixel_index <= '0;
    end else if (ctrl.init) begin
      slot        <= '0;  // init restarts the frame from pixel 0
      bit_index   <= '0;
      pixel_index <= '0;
    end else begin
      if (strb.output_en) begin
        slot <= slot + 3'd1;  // wraps from 7 to 0 on its own
      end
      if (strb.pattern_of) begin
        bit_index <= strb.bit_of ? 5'd0 : bit_index + 5'd1;
      end
      if (strb.bit_of) begin
        // last pixel wraps to 0 while the sequencer moves to the gap
        pixel_index <= strb.pixel_of ? pix_idx_t'(0) : pixel_index + index_step;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/neopixel_frame_seq.sv
`default_nettype none

`include "neopixel_macros.svh"

module neopixel_frame_seq
  import neopixel_pkg::*;
(
  input  wire logic         clk7mhz,
  input  wire logic         rst_n,
  input  wire ctrl_reg_t    ctrl,
  input  wire stream_strb_t strb,
  output seq_state_e        state
);

  localparam int GAP_BITS = $clog2(`RESET_SLOTS);

  logic [GAP_BITS-1:0] gap_cnt;  // cycles spent low in the current gap
  logic                gap_done;

  assign gap_done = (gap_cnt == GAP_BITS'(`RESET_SLOTS - 1));

  always_ff @(posedge clk7mhz or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_reset;
      gap_cnt <= '0;
    end else if (ctrl.init) begin
      state   <= st_reset;  // init always begins with a full gap
      gap_cnt <= '0;
    end else begin
      case (state)
        st_reset: begin
          // reset_en already folds in run and init so the gap freezes with run off
          if (strb.reset_en) begin
            if (gap_done) begin
              gap_cnt <= '0;
              state   <= st_transmit;
            end else begin
              gap_cnt <= gap_cnt + GAP_BITS'(1);
            end
          end
        end
        st_transmit: begin
          if (strb.bit_of && strb.pixel_of) begin
            state <= st_reset;  // last bit of the last pixel is out
          end
        end
        default: state <= st_reset;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/neopixel_bit_encoder.sv
`default_nettype none

`include "neopixel_macros.svh"

module neopixel_bit_encoder
  import neopixel_pkg::*;
(
  input  wire logic     clk7mhz,
  input  wire logic     rst_n,
  input  wire logic     output_en,
  input  wire slot_t    slot,
  input  wire bit_idx_t bit_index,
  input  wire pixel_t   rd_pixel,
  output logic          dout
);

  logic  bit_val;    // pixel bit being sent
  slot_t threshold;  // slots the line stays high for this bit
  logic  level;

  // bit 23 goes first so the stream is MSB first, green leading
  assign bit_val = rd_pixel[5'd23 - bit_index];

  assign threshold = bit_val ? slot_t'(`SLOTS_HIGH_ONE) : slot_t'(`SLOTS_HIGH_ZERO);

  // slots 0 to 2 are high for both values so a stale pixel at slot 0 does no harm
  assign level = output_en && (slot < threshold);

  // registered so the line has no glitches, it trails the slot by one cycle
  always_ff @(posedge clk7mhz or negedge rst_n) begin
    if (!rst_n) begin
      dout <= 1'b0;
    end else begin
      dout <= level;
    end
  end

endmodule

`default_nettype wire

//--- verilog/neopixel_top.sv
`default_nettype none

`include "neopixel_macros.svh"

module neopixel_top
  import neopixel_pkg::*;
(
  input  wire logic        clk7mhz,
  input  wire logic        rst_n,
  input  wire logic        psel,
  input  wire logic        penable,
  input  wire logic        pwrite,
  input  wire logic [15:0] paddr,
  input  wire logic [31:0] pwdata,
  output logic [31:0]      prdata,
  output logic             pready,
  output logic             dout
);

  ctrl_reg_t    ctrl;
  max_t         reg_max;
  logic         buf_we;
  pix_idx_t     buf_waddr;
  pixel_t       buf_wdata;
  pixel_t       rd_pixel;     // buffer entry at pixel_index, one cycle late
  seq_state_e   state;
  stream_strb_t strb;
  slot_t        slot;
  bit_idx_t     bit_index;
  pix_idx_t     pixel_index;

  neopixel_apb_regs i_regs (
    .clk7mhz (clk7mhz),
    .rst_n (rst_n),
    .psel (psel),
    .penable (penable),
    .pwrite (pwrite),
    .paddr (paddr),
    .pwdata (pwdata),
    .state (state),
    .pixel_index (pixel_index),
    .prdata (prdata),
    .pready (pready),
    .ctrl (ctrl),
    .reg_max (reg_max),
    .buf_we (buf_we),
    .buf_waddr (buf_waddr),
    .buf_wdata (buf_wdata)
  );

  neopixel_pixel_buffer #(.DEPTH(`BUFFER_END_DEFAULT + 1)) i_buffer (
    .clk7mhz (clk7mhz),
    .we (buf_we),
    .waddr (buf_waddr),
    .wdata (buf_wdata),
    .raddr (pixel_index),
    .rdata (rd_pixel)
  );

  neopixel_stream_ctrl #(.BUFFER_END(`BUFFER_END_DEFAULT)) i_stream (
    .clk7mhz (clk7mhz),
    .rst_n (rst_n),
    .ctrl (ctrl),
    .state (state),
    .reg_max (reg_max),
    .slot (slot),
    .bit_index (bit_index),
    .pixel_index (pixel_index),
    .strb (strb)
  );

  neopixel_frame_seq i_seq (
    .clk7mhz (clk7mhz),
    .rst_n (rst_n),
    .ctrl (ctrl),
    .strb (strb),
    .state (state)
  );

  neopixel_bit_encoder i_encoder (
    .clk7mhz (clk7mhz),
    .rst_n (rst_n),
    .output_en (strb.output_en),
    .slot (slot),
    .bit_index (bit_index),
    .rd_pixel (rd_pixel),
    .dout (dout)
  );

endmodule

`default_nettype wire

//--- verification/neopixel_tb.sv
`default_nettype none

`include "neopixel_macros.svh"

module neopixel_tb
  import neopixel_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_PIXELS = `BUFFER_END_DEFAULT + 1;
  localparam int FRAME_CYCLES = NUM_PIXELS * 24 * 8 + `RESET_SLOTS;  // longest frame and its gap
  // twice the time of six long frames over all tests and the run-off wait
  localparam int TIMEOUT_CYCLES = 2 * (6 * FRAME_CYCLES + 2000);
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic        clk7mhz = 1'b0;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        dout;

  logic [31:0] lfsr = 32'd27;
  pixel_t      model_buf [NUM_PIXELS];  // what firmware wrote into the buffer
  int          errors = 0;
  int          checks = 0;
  int          cycle = 0;
  int          run_cyc = 0;             // cycle at which the last run write finished

  // line decoder state is updated on the falling edge where dout is settled
  bit          decode_on = 1'b0;
  int          high_cnt = 0;
  int          low_cnt = 0;
  int          last_high = 0;
  int          nbits = 0;
  pixel_t      cur_px;
  pixel_t      cur_frame [$];
  pixel_t      last_frame [$];
  pixel_t      prev_frame [$];         // the frame before last_frame
  int          frames_done = 0;
  int          frame_gap = 0;
  int          frame_start = 0;
  int          last_gap = 0;           // low time in front of last_frame
  int          last_start = 0;

  always #4 clk7mhz = ~clk7mhz;  // 8 ns period in sim time while the DUT only counts edges

  neopixel_top i_dut (
    .clk7mhz (clk7mhz),
    .rst_n (rst_n),
    .psel (psel),
    .penable (penable),
    .pwrite (pwrite),
    .paddr (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready),
    .dout (dout)
  );

  // galois LFSR that steps once per random bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [15:0] reg_addr(input int ofs);
    return 16'(1 << `REG_WINDOW_BIT) | 16'(ofs * 4);  // word offsets in the register window
  endfunction

  task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
    @(posedge clk7mhz);
    psel    <= 1'b1;  // setup phase
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk7mhz);
    penable <= 1'b1;  // pready is tied high so the access phase ends here
    @(posedge clk7mhz);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [15:0] addr, output logic [31:0] data);
    @(posedge clk7mhz);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk7mhz);
    penable <= 1'b1;
    @(negedge clk7mhz);
    data = prdata;  // middle of the access phase
    checks++;
    if (pready !== 1'b1) begin
      $display("ERR %0t: pready low in the access phase", $time);
      errors++;
    end
    @(posedge clk7mhz);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_read(input logic [15:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] got;
    apb_read(addr, got);
    checks++;
    if (got !== exp) begin
      $display("ERR %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      errors++;
    end
  endtask

  // init, then the maximum, then the new control bits with init clear
  task automatic restart_stream(input logic [3:0] ctrl_val, input logic [12:0] max_val);
    decode_on = 1'b0;  // the frame on the line now gets cut off
    apb_write(reg_addr(`REG_CTRL_OFS), 32'h1);
    apb_write(reg_addr(`REG_MAX_OFS), {19'd0, max_val});
    apb_write(reg_addr(`REG_CTRL_OFS), {28'd0, ctrl_val});
    run_cyc = cycle;
    decode_on = 1'b1;
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = frames_done + n;
    while (frames_done < target) begin
      @(posedge clk7mhz);  // the cycle counter ends the run if no frame comes
    end
  endtask

  // expected frame built from the buffer copy, the limit and the stride
  task automatic check_frame(input bit use_prev, input bit lim, input bit s4, input int maxv);
    pixel_t got [$];
    int last_idx;
    int step;
    int n;
    if (use_prev) begin
      got = prev_frame;
    end else begin
      got = last_frame;
    end
    last_idx = lim ? maxv : `BUFFER_END_DEFAULT;
    step = s4 ? 4 : 1;
    if (s4) begin
      last_idx = last_idx - (last_idx % 4);  // last multiple of 4 not above the maximum
    end
    n = last_idx / step + 1;
    checks++;
    if (got.size() != n) begin
      $display("ERR %0t: frame holds %0d pixels, expected %0d", $time, got.size(), n);
      errors++;
    end else begin
      for (int i = 0; i < n; i++) begin
        if (got[i] !== model_buf[i * step]) begin
          $display("ERR %0t: pixel %0d is 0x%06h, expected 0x%06h of entry %0d",
                   $time, i, got[i], model_buf[i * step], i * step);
          errors++;
        end
      end
    end
    checks++;
    if (!use_prev && last_gap < `RESET_SLOTS) begin
      $display("ERR %0t: gap before frame is %0d cycles", $time, last_gap);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  // measures high pulses where 3 cycles is a 0 and 6 is a 1 and a long low ends the frame
  always @(negedge clk7mhz) begin
    if (!decode_on) begin
      high_cnt = 0;
      nbits = 0;
      cur_frame.delete();
      low_cnt = dout ? 0 : low_cnt + 1;  // keeps counting so the first gap is known
    end else if (dout) begin
      if (high_cnt == 0) begin
        if (cur_frame.size() == 0 && nbits == 0) begin
          frame_gap = low_cnt;  // first pulse of a frame
          frame_start = cycle;
        end else if (low_cnt != 8 - last_high) begin
          $display("bit at %0t ns lasted %0d cycles instead of 8", $time, low_cnt + last_high);
          errors++;
        end
      end
      high_cnt++;
      low_cnt = 0;
    end else begin
      if (high_cnt != 0) begin
        if (high_cnt == `SLOTS_HIGH_ZERO || high_cnt == `SLOTS_HIGH_ONE) begin
          cur_px = {cur_px[22:0], high_cnt == `SLOTS_HIGH_ONE};  // MSB arrives first
          nbits++;
          if (nbits == 24) begin
            cur_frame.push_back(cur_px);
            nbits = 0;
          end
        end else begin
          $display("pulse of %0d cycles ending at %0t ns is neither a 0 nor a 1",
                   high_cnt, $time);
          errors++;
        end
        last_high = high_cnt;
        high_cnt = 0;
      end
      low_cnt++;
      if (low_cnt == `RESET_SLOTS && (cur_frame.size() != 0 || nbits != 0)) begin
        if (nbits != 0) begin
          $display("frame ended after %0d bits of an unfinished pixel", nbits);
          errors++;
        end
        prev_frame = last_frame;
        last_frame = cur_frame;
        cur_frame.delete();
        nbits = 0;
        last_gap = frame_gap;
        last_start = frame_start;
        frames_done++;
      end
    end
  end

  always @(posedge clk7mhz) begin
    cycle <= cycle + 1;
    if (cycle == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the expected frames never finished", cycle);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    int          e0;
    int          maxv;
    int          highs;
    logic [31:0] v;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (8) @(posedge clk7mhz);
    rst_n <= 1'b1;

    e0 = errors;
    highs = 0;
    repeat (50) begin
      @(negedge clk7mhz);
      if (dout) highs++;
    end
    checks++;
    if (highs != 0) begin
      $display("ERR %0t: dout high for %0d cycles after reset", $time, highs);
      errors++;
    end
    check_read(reg_addr(`REG_STATUS_OFS), 32'h0, "status after reset");
    // a run bit here only starts the 400 cycle gap, so no pixel goes out
    for (int k = 0; k < 4; k++) begin
      v = rand_bits(32);
      apb_write(reg_addr(`REG_CTRL_OFS), v);
      check_read(reg_addr(`REG_CTRL_OFS), v & 32'hF, "control");
      v = rand_bits(32);
      apb_write(reg_addr(`REG_MAX_OFS), v);
      check_read(reg_addr(`REG_MAX_OFS), v & 32'h1FFF, "maximum");
    end
    check_read(reg_addr(3), 32'h0, "unmapped register");
    apb_write(16'h0010, rand_bits(32));
    check_read(16'h0010, 32'h0, "buffer entry 4");
    apb_write(reg_addr(`REG_CTRL_OFS), 32'h1);
    apb_write(reg_addr(`REG_CTRL_OFS), 32'h0);
    report_test("1 register access", e0);

    e0 = errors;
    for (int k = 0; k < NUM_PIXELS; k++) begin
      v = rand_bits(32);
      model_buf[k] = v[23:0];  // top byte is dropped by the DUT
      apb_write(16'(k * 4), v);
    end
    restart_stream(4'b0010, 13'd0);
    wait_frames(1);
    check_frame(1'b0, 1'b0, 1'b0, 0);
    report_test("2 full frame", e0);

    e0 = errors;
    maxv = int'(rand_bits(6));
    restart_stream(4'b0110, 13'(maxv));
    wait_frames(2);
    check_frame(1'b1, 1'b1, 1'b0, maxv);  // both frames must match the same model
    check_frame(1'b0, 1'b1, 1'b0, maxv);
    report_test("3 limited frame", e0);

    e0 = errors;
    maxv = int'(rand_bits(6));
    restart_stream(4'b1110, 13'(maxv));
    wait_frames(1);
    check_frame(1'b0, 1'b1, 1'b1, maxv);
    report_test("4 stride4", e0);

    e0 = errors;
    restart_stream(4'b0010, 13'd0);
    while (cur_frame.size() < 5) begin
      @(posedge clk7mhz);
    end
    decode_on = 1'b0;
    apb_write(reg_addr(`REG_CTRL_OFS), 32'h0);  // run off in the middle of a frame
    @(posedge clk7mhz);                          // dout trails by one register
    highs = 0;
    repeat (1000) begin
      @(negedge clk7mhz);
      if (dout) highs++;
    end
    checks++;
    if (highs != 0) begin
      $display("ERR %0t: dout high for %0d cycles with run off", $time, highs);
      errors++;
    end
    apb_read(reg_addr(`REG_STATUS_OFS), v);
    checks++;
    if (v[0] !== 1'b1) begin
      $display("ERR %0t: status state %0b while paused in a frame", $time, v[0]);
      errors++;
    end
    // the run bit clears while the sixth pixel is on the line
    checks++;
    if (v[13:8] !== 6'd5) begin
      $display("ERR %0t: status pixel index %0d while paused, expected 5", $time, v[13:8]);
      errors++;
    end
    restart_stream(4'b0010, 13'd0);  // init pulse, then run again
    wait_frames(1);
    check_frame(1'b0, 1'b0, 1'b0, 0);
    checks++;
    if (last_start - run_cyc < `RESET_SLOTS) begin
      $display("ERR %0t: frame began %0d cycles after run", $time, last_start - run_cyc);
      errors++;
    end
    report_test("5 run and init", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- neopixel_top.f
+incdir+include
verilog/neopixel_pkg.sv
verilog/neopixel_apb_regs.sv
verilog/neopixel_pixel_buffer.sv
verilog/neopixel_stream_ctrl.sv
verilog/neopixel_frame_seq.sv
verilog/neopixel_bit_encoder.sv
verilog/neopixel_top.sv
verification/neopixel_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f neopixel_top.f --top-module neopixel_tb \
  -Mdir obj_dir -o neopixel_sim

./obj_dir/neopixel_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
exit 0
